/* cachePkg.sv */
package cachePkg;

    localparam int WORD_BITS = 32;
    localparam int LINE_WORDS = 16;

    // Data word or byte address
    typedef logic [WORD_BITS-1:0] Word;

    // External line number from byte address bits 31 down to 6
    typedef logic [WORD_BITS-7:0] LineTag;

    typedef logic [$clog2(LINE_WORDS)-1:0] WordOffset;

    typedef enum logic {
        COPY_FILL,
        COPY_WRITEBACK
    } CopyDir;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_EVICT,
        MS_FILL,
        MS_FENCE
    } MissState;

    typedef struct packed {
        logic valid;
        logic isStore;
        Word addr;
        Word data;
    } MemUop;

    typedef struct packed {
        logic valid;
        logic isStore;
        Word slotAddr;
        Word data;
    } MemResult;

    typedef struct packed {
        logic valid;
        CopyDir dir;
        Word slot;
        LineTag tag;
    } CopyCmd;

    // Progress counts copied words and done marks a finished line
    typedef struct packed {
        logic busy;
        logic done;
        WordOffset progress;
        CopyDir dir;
    } CopyStatus;

endpackage

/* cacheController.sv */
`timescale 1ns/100ps

module cacheController #(
    parameter int SIZE = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  cachePkg::MemUop     inUop,
    output logic                stall,
    input  logic                fence,
    output logic                fenceBusy,
    output cachePkg::CopyCmd    cmdPush,
    input  logic                cmdFull,
    input  cachePkg::CopyStatus copyStatus,
    output cachePkg::MemResult  accUop
);

    localparam int SLOT_BITS = $clog2(SIZE);
    localparam int PEND_BITS = SLOT_BITS + 2;

    typedef logic [SLOT_BITS-1:0] SlotIdx;

    typedef struct packed {
        cachePkg::LineTag tag;
        logic valid;
        logic dirty;
        logic used;
    } TableEntry;

    TableEntry tbl [SIZE];
    cachePkg::MissState state;
    cachePkg::MemUop held;

    SlotIdx hand;
    SlotIdx fillSlot;
    logic fillActive;
    logic fillStarted;
    logic fencePending;
    logic [SLOT_BITS:0] walkIdx;
    logic [PEND_BITS-1:0] pending;
    logic busyQ;

    logic hitFound;
    logic freeFound;
    SlotIdx hitSlot;
    SlotIdx freeSlot;
    SlotIdx walkSlot;
    SlotIdx accSlot;
    logic walkDone;
    logic fillCopying;
    logic fillEnded;
    logic copyEnded;
    logic inReady;
    logic heldReady;
    cachePkg::WordOffset inOff;
    cachePkg::WordOffset heldOff;

    function automatic cachePkg::MemResult translate(cachePkg::MemUop u, SlotIdx s);
        cachePkg::MemResult r;
        r.valid = 1'b1;
        r.isStore = u.isStore;
        r.slotAddr = cachePkg::Word'({s, u.addr[5:0]});
        r.data = u.isStore ? u.data : '0;
        return r;
    endfunction

    // Tag match and lowest free slot
    always_comb begin
        hitFound = 1'b0;
        hitSlot = '0;
        freeFound = 1'b0;
        freeSlot = '0;
        for (int i = 0; i < SIZE; i++) begin
            if (tbl[i].valid && tbl[i].tag == inUop.addr[31:6]) begin
                hitFound = 1'b1;
                hitSlot = SlotIdx'(i);
            end
            if (!tbl[i].valid && !freeFound) begin
                freeFound = 1'b1;
                freeSlot = SlotIdx'(i);
            end
        end
    end

    assign inOff = inUop.addr[5:2];
    assign heldOff = held.addr[5:2];
    assign walkSlot = walkIdx[SLOT_BITS-1:0];
    assign walkDone = walkIdx == (SLOT_BITS+1)'(SIZE);
    assign accSlot = accUop.slotAddr[SLOT_BITS+5:6];

    // Only one fill is ever outstanding, so a running fill is ours
    assign fillCopying = fillActive && copyStatus.busy && copyStatus.dir == cachePkg::COPY_FILL;
    assign fillEnded = fillStarted && copyStatus.done;
    assign copyEnded = busyQ && !copyStatus.busy;

    assign inReady = !fillActive || hitSlot != fillSlot || fillEnded ||
        (fillCopying && copyStatus.progress > inOff);
    assign heldReady = !fillActive || fillEnded || (fillCopying && copyStatus.progress > heldOff);

    assign stall = state != cachePkg::MS_IDLE || fencePending;
    assign fenceBusy = state == cachePkg::MS_FENCE || fencePending;

    always_comb begin
        cmdPush = '0;
        if (!cmdFull) begin
            if (state == cachePkg::MS_EVICT && !fillActive) begin
                if (freeFound) begin
                    cmdPush.valid = 1'b1;
                    cmdPush.dir = cachePkg::COPY_FILL;
                    cmdPush.slot = cachePkg::Word'(freeSlot);
                    cmdPush.tag = held.addr[31:6];
                end else if (!tbl[hand].used && tbl[hand].dirty) begin
                    cmdPush.valid = 1'b1;
                    cmdPush.dir = cachePkg::COPY_WRITEBACK;
                    cmdPush.slot = cachePkg::Word'(hand);
                    cmdPush.tag = tbl[hand].tag;
                end
            end else if (state == cachePkg::MS_FENCE && !walkDone &&
                tbl[walkSlot].valid && tbl[walkSlot].dirty) begin
                cmdPush.valid = 1'b1;
                cmdPush.dir = cachePkg::COPY_WRITEBACK;
                cmdPush.slot = cachePkg::Word'(walkSlot);
                cmdPush.tag = tbl[walkSlot].tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SIZE; i++) begin
                tbl[i].valid <= 1'b0;
                tbl[i].dirty <= 1'b0;
                tbl[i].used <= 1'b0;
            end
            state <= cachePkg::MS_IDLE;
            hand <= '0;
            fillActive <= 1'b0;
            fillStarted <= 1'b0;
            fencePending <= 1'b0;
            walkIdx <= '0;
            pending <= '0;
            busyQ <= 1'b0;
            accUop.valid <= 1'b0;
        end else begin
            accUop.valid <= 1'b0;
            busyQ <= copyStatus.busy;
            pending <= pending + PEND_BITS'(cmdPush.valid) - PEND_BITS'(copyEnded);

            if (fillCopying) begin
                fillStarted <= 1'b1;
            end
            if (fillEnded) begin
                fillActive <= 1'b0;
                fillStarted <= 1'b0;
            end

            if (fence && state != cachePkg::MS_FENCE) begin
                fencePending <= 1'b1;
            end

            case (state)
                cachePkg::MS_IDLE: begin
                    if (fencePending) begin
                        fencePending <= 1'b0;
                        walkIdx <= '0;
                        state <= cachePkg::MS_FENCE;
                    end else if (inUop.valid) begin
                        if (hitFound && inReady) begin
                            accUop <= translate(inUop, hitSlot);
                            tbl[hitSlot].used <= 1'b1;
                            if (inUop.isStore) begin
                                tbl[hitSlot].dirty <= 1'b1;
                            end
                        end else begin
                            // Hit on a word still in flight waits like a miss
                            held <= inUop;
                            state <= hitFound ? cachePkg::MS_FILL : cachePkg::MS_EVICT;
                        end
                    end
                end
                cachePkg::MS_EVICT: begin
                    if (!fillActive) begin
                        if (freeFound) begin
                            if (cmdPush.valid) begin
                                tbl[freeSlot] <= '{tag: held.addr[31:6], valid: 1'b1,
                                    dirty: 1'b0, used: 1'b1};
                                fillActive <= 1'b1;
                                fillSlot <= freeSlot;
                                state <= cachePkg::MS_FILL;
                            end
                        end else if (tbl[hand].used) begin
                            tbl[hand].used <= 1'b0;
                            hand <= hand + 1'b1;
                        end else if (!tbl[hand].dirty || cmdPush.valid) begin
                            // Freed slot is picked up as the lowest invalid next cycle
                            tbl[hand].valid <= 1'b0;
                            tbl[hand].dirty <= 1'b0;
                            hand <= hand + 1'b1;
                        end
                    end
                end
                cachePkg::MS_FILL: begin
                    if (heldReady) begin
                        accUop <= translate(held, fillSlot);
                        tbl[fillSlot].used <= 1'b1;
                        if (held.isStore) begin
                            tbl[fillSlot].dirty <= 1'b1;
                        end
                        state <= cachePkg::MS_IDLE;
                    end
                end
                cachePkg::MS_FENCE: begin
                    if (!walkDone) begin
                        if (!(tbl[walkSlot].valid && tbl[walkSlot].dirty) || cmdPush.valid) begin
                            tbl[walkSlot].valid <= 1'b0;
                            tbl[walkSlot].dirty <= 1'b0;
                            tbl[walkSlot].used <= 1'b0;
                            walkIdx <= walkIdx + 1'b1;
                        end
                    end else if (pending == '0) begin
                        state <= cachePkg::MS_IDLE;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        accUop.valid |-> tbl[accSlot].valid || (fillActive && fillSlot == accSlot))
        else $error("access issued to slot %0d which is neither valid nor filling", accSlot);

endmodule

/* memCmdFifo.sv */
`timescale 1ns/100ps

module memCmdFifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  cachePkg::CopyCmd push,
    output logic             full,
    input  logic             engineBusy,
    output cachePkg::CopyCmd cmd,
    output logic             cmdStart
);

    localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    cachePkg::CopyCmd mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0] wrPtr;
    logic [PTR_BITS-1:0] rdPtr;
    logic [PTR_BITS:0] count;
    logic pop;

    assign full = count == (PTR_BITS+1)'(FIFO_DEPTH);

    // The command in flight on cmdStart has not raised busy yet
    assign pop = count != '0 && !engineBusy && !cmdStart;

    always_ff @(posedge clk) begin
        if (push.valid) begin
            mem[wrPtr] <= push;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            cmdStart <= 1'b0;
            cmd.valid <= 1'b0;
        end else begin
            if (push.valid) begin
                wrPtr <= (wrPtr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
                cmd <= mem[rdPtr];
            end
            count <= count + (PTR_BITS+1)'(push.valid) - (PTR_BITS+1)'(pop);
            cmdStart <= pop;
        end
    end

    assert property (@(posedge clk) disable iff (rst) push.valid |-> !full)
        else $error("push into full command FIFO");

endmodule

/* memCopyEngine.sv */
`timescale 1ns/100ps

module memCopyEngine #(
    parameter int SIZE = 8,
    parameter int EXT_LINES = 64
) (
    input  logic                clk,
    input  logic                rst,
    input  cachePkg::CopyCmd    cmd,
    input  logic                cmdStart,
    output cachePkg::CopyStatus status,
    input  cachePkg::MemResult  accUop,
    output cachePkg::MemResult  result
);

    localparam int SLOT_BITS = $clog2(SIZE);
    localparam int EXT_BITS = $clog2(EXT_LINES);
    localparam int OFF_BITS = $clog2(cachePkg::LINE_WORDS);

    cachePkg::Word sram [SIZE * cachePkg::LINE_WORDS];
    cachePkg::Word extMem [EXT_LINES * cachePkg::LINE_WORDS];

    logic busy;
    logic done;
    cachePkg::WordOffset progress;
    logic [SLOT_BITS-1:0] curSlot;
    cachePkg::LineTag curTag;
    cachePkg::CopyDir curDir;

    logic [SLOT_BITS+OFF_BITS-1:0] sramIdx;
    logic [SLOT_BITS+OFF_BITS-1:0] accIdx;
    logic [EXT_BITS+OFF_BITS-1:0] extIdx;

    assign sramIdx = {curSlot, progress};
    assign extIdx = {curTag[EXT_BITS-1:0], progress};
    assign accIdx = accUop.slotAddr[SLOT_BITS+OFF_BITS+1:2];

    assign status.busy = busy;
    assign status.done = done;
    assign status.progress = progress;
    assign status.dir = curDir;

    // External memory model starts as word address XOR a fixed pattern
    initial begin
        for (int w = 0; w < EXT_LINES * cachePkg::LINE_WORDS; w++) begin
            extMem[w] = cachePkg::Word'(w) ^ 32'hA5A50000;
        end
    end

    always @(posedge clk) begin
        if (busy && curDir == cachePkg::COPY_WRITEBACK) begin
            extMem[extIdx] <= sram[sramIdx];
        end
    end

    // Line copy and uop store share the SRAM on different words
    always_ff @(posedge clk) begin
        if (busy && curDir == cachePkg::COPY_FILL) begin
            sram[sramIdx] <= extMem[extIdx];
        end
        if (accUop.valid && accUop.isStore) begin
            sram[accIdx] <= accUop.data;
        end
    end

    always_ff @(posedge clk) begin
        if (cmdStart && cmd.valid) begin
            curSlot <= cmd.slot[SLOT_BITS-1:0];
            curTag <= cmd.tag;
            curDir <= cmd.dir;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            progress <= '0;
        end else if (cmdStart && cmd.valid) begin
            busy <= 1'b1;
            done <= 1'b0;
            progress <= '0;
        end else if (busy) begin
            progress <= progress + 1'b1;
            if (progress == OFF_BITS'(cachePkg::LINE_WORDS - 1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= accUop.valid;
            result.isStore <= accUop.isStore;
            result.slotAddr <= accUop.slotAddr;
            result.data <= accUop.isStore ? accUop.data : sram[accIdx];
        end
    end

    assert property (@(posedge clk) disable iff (rst) cmdStart |-> !busy)
        else $error("copy command started while engine busy");

endmodule

/* cacheTop.sv */
`timescale 1ns/100ps

module cacheTop #(
    parameter int SIZE = 8,
    parameter int FIFO_DEPTH = 4,
    parameter int EXT_LINES = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  cachePkg::MemUop    inUop,
    output logic               stall,
    input  logic               fence,
    output logic               fenceBusy,
    output cachePkg::MemResult result
);

    cachePkg::CopyCmd cmdPush;
    logic cmdFull;
    cachePkg::CopyCmd cmd;
    logic cmdStart;
    cachePkg::CopyStatus copyStatus;
    cachePkg::MemResult accUop;

    cacheController #(
        .SIZE(SIZE)
    ) cacheController_i (
        .clk(clk),
        .rst(rst),
        .inUop(inUop),
        .stall(stall),
        .fence(fence),
        .fenceBusy(fenceBusy),
        .cmdPush(cmdPush),
        .cmdFull(cmdFull),
        .copyStatus(copyStatus),
        .accUop(accUop)
    );

    memCmdFifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) memCmdFifo_i (
        .clk(clk),
        .rst(rst),
        .push(cmdPush),
        .full(cmdFull),
        .engineBusy(copyStatus.busy),
        .cmd(cmd),
        .cmdStart(cmdStart)
    );

    memCopyEngine #(
        .SIZE(SIZE),
        .EXT_LINES(EXT_LINES)
    ) memCopyEngine_i (
        .clk(clk),
        .rst(rst),
        .cmd(cmd),
        .cmdStart(cmdStart),
        .status(copyStatus),
        .accUop(accUop),
        .result(result)
    );

endmodule

/* cacheTb.sv */
`timescale 1ns/100ps

module cacheTb;

    localparam int SIZE = 8;
    localparam int FIFO_DEPTH = 4;
    localparam int EXT_LINES = 64;
    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS = 5;
    localparam int CYCLES_PER_TEST = 400;
    localparam int WAIT_LIMIT = 200;
    localparam int LINE_BYTES = cachePkg::LINE_WORDS * 4;
    localparam int STORE_ADDR = LINE_BYTES + 3 * 4;

    logic clk;
    logic rst;
    cachePkg::MemUop inUop;
    logic stall;
    logic fence;
    logic fenceBusy;
    cachePkg::MemResult result;

    // Expected external memory contents by word address
    cachePkg::Word shadow [EXT_LINES * cachePkg::LINE_WORDS];
    int seed = 28;

    cacheTop #(
        .SIZE(SIZE),
        .FIFO_DEPTH(FIFO_DEPTH),
        .EXT_LINES(EXT_LINES)
    ) cacheTop_i (
        .clk(clk),
        .rst(rst),
        .inUop(inUop),
        .stall(stall),
        .fence(fence),
        .fenceBusy(fenceBusy),
        .result(result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Timeout: tests still running after %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
        stopOnFailure();
    end

    task automatic stopOnFailure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic cachePkg::Word initialWord(int wordAddr);
        return cachePkg::Word'(wordAddr) ^ 32'hA5A50000;
    endfunction

    // SRAM byte address of a line placed in the given slot
    function automatic cachePkg::Word slotAddress(int slot, cachePkg::Word addr);
        return cachePkg::Word'(slot * LINE_BYTES) + (addr % LINE_BYTES);
    endfunction

    task automatic compareData(string name, cachePkg::Word got, cachePkg::Word expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
            stopOnFailure();
        end
    endtask

    task automatic compareSlotAddr(string name, cachePkg::Word got, cachePkg::Word expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
            stopOnFailure();
        end
    endtask

    task automatic compareFlag(string name, logic got, logic expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, expected);
            stopOnFailure();
        end
    endtask

    task automatic expectLatency(string name, int got, int expected);
        if (got != expected) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, expected);
            stopOnFailure();
        end
    endtask

    task automatic issueUop(input logic isStore, input cachePkg::Word addr,
            input cachePkg::Word data, output cachePkg::MemResult res, output int latency);
        cachePkg::MemUop uop;
        int waited;
        uop.valid = 1'b1;
        uop.isStore = isStore;
        uop.addr = addr;
        uop.data = data;
        waited = 0;
        @(posedge clk);
        inUop <= uop;
        // Taken at the first edge that sees stall low
        @(negedge clk);
        while (stall) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Uop to address %h was never accepted, stall stayed high", addr);
                stopOnFailure();
            end
            @(negedge clk);
        end
        @(posedge clk);
        inUop <= '0;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
            if (latency > WAIT_LIMIT) begin
                $display("No result came back for the uop to address %h", addr);
                stopOnFailure();
            end
        end while (!result.valid);
        res = result;
        compareFlag("result.isStore", res.isStore, isStore);
    endtask

    task automatic loadWord(input cachePkg::Word addr, output cachePkg::MemResult res,
            output int latency);
        issueUop(1'b0, addr, '0, res, latency);
        compareData("result.data", res.data, shadow[addr / 4]);
    endtask

    task automatic storeWord(input cachePkg::Word addr, input cachePkg::Word data,
            output cachePkg::MemResult res, output int latency);
        issueUop(1'b1, addr, data, res, latency);
        shadow[addr / 4] = data;
        compareData("result.data", res.data, data);
    endtask

    task automatic pulseFence();
        @(posedge clk);
        fence <= 1'b1;
        @(posedge clk);
        fence <= 1'b0;
    endtask

    task automatic waitFence();
        int cycles;
        logic seenBusy;
        cycles = 0;
        seenBusy = 1'b0;
        while (!seenBusy || fenceBusy) begin
            @(negedge clk);
            if (fenceBusy) begin
                seenBusy = 1'b1;
            end
            cycles++;
            if (cycles > CYCLES_PER_TEST) begin
                $display("Fence did not complete, fenceBusy never fell");
                stopOnFailure();
            end
        end
    endtask

    task automatic fillInOrder();
        cachePkg::MemResult res;
        cachePkg::Word addr;
        int latency;
        for (int i = 0; i < SIZE; i++) begin
            addr = cachePkg::Word'(i * LINE_BYTES + ((i * 5) % cachePkg::LINE_WORDS) * 4);
            loadWord(addr, res, latency);
            compareSlotAddr("result.slotAddr", res.slotAddr, slotAddress(i, addr));
        end
    endtask

    task automatic hitLatency();
        cachePkg::MemResult res;
        int latency;
        loadWord(cachePkg::Word'(9 * 4), res, latency);
        compareSlotAddr("result.slotAddr", res.slotAddr, slotAddress(0, 9 * 4));
        expectLatency("result latency", latency, 2);
    endtask

    task automatic storeThenLoad();
        cachePkg::MemResult res;
        int latency;
        storeWord(STORE_ADDR, $random(seed), res, latency);
        compareSlotAddr("result.slotAddr", res.slotAddr, slotAddress(1, STORE_ADDR));
        loadWord(STORE_ADDR, res, latency);
        compareSlotAddr("result.slotAddr", res.slotAddr, slotAddress(1, STORE_ADDR));
        expectLatency("result latency", latency, 2);
    endtask

    task automatic evictAndReload();
        cachePkg::MemResult res;
        cachePkg::Word addrs [SIZE + 4];
        bit taken [EXT_LINES];
        int line;
        int latency;
        for (int i = 0; i < EXT_LINES; i++) begin
            taken[i] = i < SIZE;
        end
        for (int i = 0; i < SIZE + 4; i++) begin
            do begin
                line = SIZE + int'($unsigned($random(seed)) % (EXT_LINES - SIZE));
            end while (taken[line]);
            taken[line] = 1'b1;
            addrs[i] = cachePkg::Word'(line * LINE_BYTES +
                ($unsigned($random(seed)) % cachePkg::LINE_WORDS) * 4);
            if (i % 2 == 0) begin
                storeWord(addrs[i], $random(seed), res, latency);
            end else begin
                loadWord(addrs[i], res, latency);
            end
        end
        // Line 1 was dirty and has been evicted by now
        loadWord(STORE_ADDR, res, latency);
        loadWord(STORE_ADDR + 4, res, latency);
        for (int i = 0; i < SIZE + 4; i += 2) begin
            loadWord(addrs[i], res, latency);
        end
    endtask

    task automatic fenceAndRefill();
        cachePkg::MemResult res;
        cachePkg::Word addrs [3];
        int latency;
        for (int i = 0; i < 3; i++) begin
            addrs[i] = cachePkg::Word'((3 + i) * LINE_BYTES + (i * 4 + 2) * 4);
            storeWord(addrs[i], $random(seed), res, latency);
        end
        pulseFence();
        waitFence();
        // Every slot is empty again, so refills start at slot 0
        for (int i = 0; i < 3; i++) begin
            loadWord(addrs[i], res, latency);
            compareSlotAddr("result.slotAddr", res.slotAddr, slotAddress(i, addrs[i]));
        end
    endtask

    initial begin
        rst = 1'b1;
        fence = 1'b0;
        inUop = '0;
        for (int w = 0; w < EXT_LINES * cachePkg::LINE_WORDS; w++) begin
            shadow[w] = initialWord(w);
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        fillInOrder();
        hitLatency();
        storeThenLoad();
        evictAndReload();
        fenceAndRefill();
        repeat (2) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* vlog.f */
cachePkg.sv
cacheController.sv
memCmdFifo.sv
memCopyEngine.sv
cacheTop.sv
cacheTb.sv

/* Bender.yml */
package:
  name: lineCache

sources:
  - cachePkg.sv
  - cacheController.sv
  - memCmdFifo.sv
  - memCopyEngine.sv
  - cacheTop.sv
  - target: test
    files:
      - cacheTb.sv
